/* sim.f */
+incdir+include
logic/router_pkg.sv
logic/stream_sof.sv
logic/meta_fifo.sv
logic/ctrl_regs.sv
logic/echo_engine.sv
logic/port_map_wrapper.sv
logic/router_top.sv
bench/router_tb.sv

/* Makefile */
# Verilator build and run for the router testbench

VERILATOR ?= verilator
TOP       ?= router_tb
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All checks passed
VFLAGS    ?= --binary --timing --assert --timescale 1ns/10ps

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# pass only if the log holds the pass line
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* include/router_tb_checks.svh */
//////////////////////////////////////////////////
// router testbench checks
// output beats and metadata against scoreboard heads
//////////////////////////////////////////////////

`ifndef ROUTER_TB_CHECKS_SVH
`define ROUTER_TB_CHECKS_SVH

    ////////////////////////////////////////////////
    // data beats

    a_beat_expected: assert property (@(posedge clk) disable iff (rst)
        out_xfer |-> exp_beat_vld)
        else begin
            beat_errs++;
            $display("output beat at %0t arrived with nothing sent", $time);
        end

    a_tdata: assert property (@(posedge clk) disable iff (rst)
        out_xfer |-> (out_tdata == exp_beat.data))
        else begin
            beat_errs++;
            $display("mismatch t=%0t out_tdata exp %h got %h",
                     $time, $sampled(exp_beat.data), $sampled(out_tdata));
        end

    a_tkeep: assert property (@(posedge clk) disable iff (rst)
        out_xfer |-> (out_tkeep == exp_beat.keep))
        else begin
            beat_errs++;
            $display("mismatch t=%0t out_tkeep exp %h got %h",
                     $time, $sampled(exp_beat.keep), $sampled(out_tkeep));
        end

    a_tlast: assert property (@(posedge clk) disable iff (rst)
        out_xfer |-> (out_tlast == exp_beat.last))
        else begin
            beat_errs++;
            $display("mismatch t=%0t out_tlast exp %b got %b",
                     $time, $sampled(exp_beat.last), $sampled(out_tlast));
        end

    ////////////////////////////////////////////////
    // metadata checked on every beat of the frame

    a_ing_port: assert property (@(posedge clk) disable iff (rst)
        out_xfer |-> (exp_meta_vld && out_tuser.ingress_port == exp_meta.ingress_port))
        else begin
            meta_errs++;
            $display("mismatch t=%0t out_tuser.ingress_port exp %0d got %0d",
                     $time, $sampled(exp_meta.ingress_port), $sampled(out_tuser.ingress_port));
        end

    a_egr_port: assert property (@(posedge clk) disable iff (rst)
        out_xfer |-> (out_tuser.egress_port == exp_meta.egress_port))
        else begin
            meta_errs++;
            $display("mismatch t=%0t out_tuser.egress_port exp %0d got %0d",
                     $time, $sampled(exp_meta.egress_port), $sampled(out_tuser.egress_port));
        end

    a_prio: assert property (@(posedge clk) disable iff (rst)
        out_xfer |-> (out_tuser.prio == exp_meta.prio))
        else begin
            meta_errs++;
            $display("mismatch t=%0t out_tuser.prio exp %0d got %0d",
                     $time, $sampled(exp_meta.prio), $sampled(out_tuser.prio));
        end

    a_len: assert property (@(posedge clk) disable iff (rst)
        out_xfer |-> (out_tuser.byte_length == exp_meta.byte_length))
        else begin
            meta_errs++;
            $display("mismatch t=%0t out_tuser.byte_length exp %0d got %0d",
                     $time, $sampled(exp_meta.byte_length), $sampled(out_tuser.byte_length));
        end

    ////////////////////////////////////////////////
    // protocol and status

    a_reset_idle: assert property (@(posedge clk)
        rst |=> !out_tvalid)
        else begin
            proto_errs++;
            $display("out_tvalid high right after reset at %0t", $time);
        end

    a_stall_hold: assert property (@(posedge clk) disable iff (rst)
        (out_tvalid && !out_tready) |=> (out_tvalid && $stable(out_tdata)
            && $stable(out_tkeep) && $stable(out_tlast) && $stable(out_tuser)))
        else begin
            proto_errs++;
            $display("output changed while stalled at %0t", $time);
        end

    a_no_overflow: assert property (@(posedge clk) disable iff (rst)
        !meta_overflow)
        else begin
            proto_errs++;
            $display("meta_overflow went high at %0t", $time);
        end

    a_readback: assert property (@(posedge clk) disable iff (rst)
        rd_check |-> (ctrl_rdata == rd_exp))
        else begin
            read_errs++;
            $display("mismatch t=%0t ctrl_rdata addr %0d exp %0d got %0d",
                     $time, $sampled(ctrl_req.addr), $sampled(rd_exp), $sampled(ctrl_rdata));
        end

`endif

/* bench/router_tb.sv */
//////////////////////////////////////////////////
// router testbench
// random frames, priority rewrites, read-back
//////////////////////////////////////////////////

`timescale 1ns/10ps

module router_tb;

    import router_pkg::*;

    localparam int BUS_BYTES   = 8;
    localparam int CLK_NS      = 4;
    localparam int RST_CYC     = 8;
    localparam int NUM_FRAMES  = 40;
    localparam int TIMEOUT_CYC = NUM_FRAMES * 40 + 200;   // table setup and read-back fit

    typedef struct packed {
        logic [BUS_BYTES*8-1:0] data;
        logic [BUS_BYTES-1:0]   keep;
        logic                   last;
    } beat_t;

    logic                   clk = 1'b0;
    logic                   rst = 1'b1;
    logic [BUS_BYTES*8-1:0] in_tdata;
    logic [BUS_BYTES-1:0]   in_tkeep;
    logic                   in_tlast;
    ing_meta_t              in_tuser;
    logic                   in_tvalid;
    logic                   in_tready;
    logic [BUS_BYTES*8-1:0] out_tdata;
    logic [BUS_BYTES-1:0]   out_tkeep;
    logic                   out_tlast;
    egr_meta_t              out_tuser;
    logic                   out_tvalid;
    logic                   out_tready;
    ctrl_req_t              ctrl_req;
    logic [CTRL_DW-1:0]     ctrl_rdata;
    logic                   meta_overflow;
    logic                   out_xfer;

    ////////////////////////////////////////////////
    // scoreboard state

    beat_t              beat_q [$];             // beats in flight, send order
    egr_meta_t          meta_q [$];             // one entry per frame
    beat_t              exp_beat;
    beat_t              popped;
    egr_meta_t          exp_meta;
    logic               exp_beat_vld = 1'b0;
    logic               exp_meta_vld = 1'b0;
    logic               mon_in_frame;
    logic               pop_pending;
    logic               last_pending;
    logic [PRIO_W-1:0]  prio_model [NUM_PORTS]; // what the table should hold
    logic               rd_check;
    logic [CTRL_DW-1:0] rd_exp;
    int                 recv_frames;
    int                 beat_errs;
    int                 meta_errs;
    int                 proto_errs;
    int                 read_errs;
    integer             seed;

    assign out_xfer = out_tvalid && out_tready;

    router_top #(
        .DATA_BYTES ( BUS_BYTES )
    ) uut (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .in_tdata      ( in_tdata      ),
        .in_tkeep      ( in_tkeep      ),
        .in_tlast      ( in_tlast      ),
        .in_tuser      ( in_tuser      ),
        .in_tvalid     ( in_tvalid     ),
        .in_tready     ( in_tready     ),
        .out_tdata     ( out_tdata     ),
        .out_tkeep     ( out_tkeep     ),
        .out_tlast     ( out_tlast     ),
        .out_tuser     ( out_tuser     ),
        .out_tvalid    ( out_tvalid    ),
        .out_tready    ( out_tready    ),
        .ctrl_req      ( ctrl_req      ),
        .ctrl_rdata    ( ctrl_rdata    ),
        .meta_overflow ( meta_overflow )
    );

    `include "router_tb_checks.svh"

    initial begin
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // expected egress view of a frame as its first beat goes in
    function automatic egr_meta_t expect_meta(input ing_meta_t m);
        egr_meta_t e;
        e.ingress_port = m.ingress_port;
        e.egress_port  = m.ingress_port ^ PORT_W'(1);  // pairwise loopback
        e.prio         = prio_model[m.ingress_port];
        e.byte_length  = m.byte_length;
        return e;
    endfunction

    function automatic int total_errors();
        return beat_errs + meta_errs + proto_errs + read_errs;
    endfunction

    ////////////////////////////////////////////////
    // monitor on the falling edge where all values are settled

    always @(negedge clk) begin
        if (rst) begin
            beat_q.delete();
            meta_q.delete();
            mon_in_frame = 1'b0;
            pop_pending  = 1'b0;
            last_pending = 1'b0;
        end else begin
            if (pop_pending && beat_q.size() > 0) begin
                popped = beat_q.pop_front();
                if (popped.last && meta_q.size() > 0) begin
                    void'(meta_q.pop_front());       // frame retired
                end
            end
            if (last_pending) begin
                recv_frames++;
            end
            if (in_tvalid && in_tready) begin
                beat_q.push_back('{data: in_tdata, keep: in_tkeep, last: in_tlast});
                if (!mon_in_frame) begin
                    meta_q.push_back(expect_meta(in_tuser));
                end
                mon_in_frame = !in_tlast;
            end
            exp_beat_vld = (beat_q.size() > 0);
            exp_meta_vld = (meta_q.size() > 0);
            if (exp_beat_vld) begin
                exp_beat = beat_q[0];
            end
            if (exp_meta_vld) begin
                exp_meta = meta_q[0];
            end
            pop_pending  = out_xfer;            // consumed on the coming edge
            last_pending = out_xfer && out_tlast;
        end
    end

    ////////////////////////////////////////////////
    // stimulus

    task automatic next_cycle();
        @(posedge clk);
        #1;
        out_tready = (($random(seed) & 3) != 0);    // ready about 3 cycles in 4
    endtask

    task automatic write_prio(input int port, input logic [CTRL_DW-1:0] val);
        ctrl_req          = '{wr: 1'b1, addr: CTRL_AW'(port), wdata: val};
        prio_model[port]  = val[PRIO_W-1:0];
        next_cycle();
        ctrl_req.wr       = 1'b0;
    endtask

    task automatic send_frame(input int port, input int beats);
        int        last_bytes;
        logic      acc;
        ing_meta_t meta;
        last_bytes       = ($unsigned($random(seed)) % BUS_BYTES) + 1;
        meta.ingress_port = PORT_W'(port);
        meta.byte_length  = LEN_W'((beats - 1) * BUS_BYTES + last_bytes);
        for (int b = 0; b < beats; b++) begin
            in_tvalid = 1'b1;
            in_tdata  = {$random(seed), $random(seed)};
            in_tlast  = (b == beats - 1);
            in_tkeep  = in_tlast ? BUS_BYTES'((1 << last_bytes) - 1) : '1;
            if (b == 0) begin
                in_tuser = meta;
            end else begin
                // junk after the first beat that the DUT must ignore
                in_tuser = '{ingress_port: ~meta.ingress_port, byte_length: ~meta.byte_length};
            end
            do begin
                @(negedge clk);
                acc = in_tready;
                next_cycle();
            end while (!acc);
        end
        in_tvalid = 1'b0;
        in_tlast  = 1'b0;
    endtask

    task automatic read_back(input int addr, input logic [CTRL_DW-1:0] expect_val);
        ctrl_req = '{wr: 1'b0, addr: CTRL_AW'(addr), wdata: '0};
        rd_exp   = expect_val;
        rd_check = 1'b1;
        next_cycle();
    endtask

    task automatic print_counts();
        $display("error counts: beat %0d, meta %0d, protocol %0d, readback %0d, total %0d",
                 beat_errs, meta_errs, proto_errs, read_errs, total_errors());
    endtask

    initial begin
        int               port;
        int               beats;
        logic [CTRL_DW-1:0] val;
        seed        = 32'h9de9_2754;
        in_tvalid   = 1'b0;
        in_tdata    = '0;
        in_tkeep    = '0;
        in_tlast    = 1'b0;
        in_tuser    = '0;
        out_tready  = 1'b0;
        ctrl_req    = '0;
        rd_check    = 1'b0;
        rd_exp      = '0;
        recv_frames = 0;
        beat_errs   = 0;
        meta_errs   = 0;
        proto_errs  = 0;
        read_errs   = 0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            prio_model[p] = '0;                 // reset value of the table
        end
        repeat (RST_CYC) @(posedge clk);
        #1;
        rst = 1'b0;
        for (int p = 0; p < NUM_PORTS; p++) begin
            val = $random(seed);
            write_prio(p, val);
        end
        for (int f = 0; f < NUM_FRAMES; f++) begin
            port  = $unsigned($random(seed)) % NUM_PORTS;
            beats = ($unsigned($random(seed)) % 6) + 1;
            if ($random(seed) & 1) begin        // new priority for the coming frame's port
                val = $random(seed);
                write_prio(port, val);
            end
            send_frame(port, beats);
        end
        while (recv_frames < NUM_FRAMES) begin
            next_cycle();
        end
        for (int a = 0; a < NUM_PORTS; a++) begin
            read_back(a, CTRL_DW'(prio_model[a]));
        end
        read_back(CNT_ADDR, CTRL_DW'(NUM_FRAMES));
        rd_check = 1'b0;
        next_cycle();
        print_counts();
        if (total_errors() == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        #(TIMEOUT_CYC * CLK_NS);
        $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYC);
        print_counts();
        $display("Checks failed");
        $finish;
    end

endmodule

/* logic/router_top.sv */
//////////////////////////////////////////////////
// packet router top level
//////////////////////////////////////////////////

`timescale 1ns/10ps

module router_top #(
    parameter int DATA_BYTES = router_pkg::DATA_BYTES
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [DATA_BYTES*8-1:0]         in_tdata,
    input  logic [DATA_BYTES-1:0]           in_tkeep,
    input  logic                            in_tlast,
    input  router_pkg::ing_meta_t           in_tuser,
    input  logic                            in_tvalid,
    output logic                            in_tready,
    output logic [DATA_BYTES*8-1:0]         out_tdata,
    output logic [DATA_BYTES-1:0]           out_tkeep,
    output logic                            out_tlast,
    output router_pkg::egr_meta_t           out_tuser,
    output logic                            out_tvalid,
    input  logic                            out_tready,
    input  router_pkg::ctrl_req_t           ctrl_req,
    output logic [router_pkg::CTRL_DW-1:0]  ctrl_rdata,
    output logic                            meta_overflow   // sticky status
);

    port_map_wrapper #(
        .DATA_BYTES ( DATA_BYTES )
    ) u_wrapper (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .in_tdata      ( in_tdata      ),
        .in_tkeep      ( in_tkeep      ),
        .in_tlast      ( in_tlast      ),
        .in_tuser      ( in_tuser      ),
        .in_tvalid     ( in_tvalid     ),
        .in_tready     ( in_tready     ),
        .out_tdata     ( out_tdata     ),
        .out_tkeep     ( out_tkeep     ),
        .out_tlast     ( out_tlast     ),
        .out_tuser     ( out_tuser     ),
        .out_tvalid    ( out_tvalid    ),
        .out_tready    ( out_tready    ),
        .ctrl_req      ( ctrl_req      ),
        .ctrl_rdata    ( ctrl_rdata    ),
        .meta_overflow ( meta_overflow )
    );

endmodule

/* logic/port_map_wrapper.sv */
//////////////////////////////////////////////////
// port-mapping wrapper
// maps stream metadata around the engine, pairwise loopback
//////////////////////////////////////////////////

`timescale 1ns/10ps

module port_map_wrapper #(
    parameter int DATA_BYTES = router_pkg::DATA_BYTES
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [DATA_BYTES*8-1:0]         in_tdata,
    input  logic [DATA_BYTES-1:0]           in_tkeep,
    input  logic                            in_tlast,
    input  router_pkg::ing_meta_t           in_tuser,
    input  logic                            in_tvalid,
    output logic                            in_tready,
    output logic [DATA_BYTES*8-1:0]         out_tdata,
    output logic [DATA_BYTES-1:0]           out_tkeep,
    output logic                            out_tlast,
    output router_pkg::egr_meta_t           out_tuser,
    output logic                            out_tvalid,
    input  logic                            out_tready,
    input  router_pkg::ctrl_req_t           ctrl_req,
    output logic [router_pkg::CTRL_DW-1:0]  ctrl_rdata,
    output logic                            meta_overflow
);

    import router_pkg::*;

    user_meta_t meta_to_eng;
    user_meta_t meta_from_eng;
    logic       sof;

    // even port n goes to n+1, odd port n to n-1
    function automatic logic [PORT_W-1:0] egress_map(input logic [PORT_W-1:0] ing_id);
        return {ing_id[PORT_W-1:1], ~ing_id[0]};
    endfunction

    ////////////////////////////////////////////////
    // ingress side

    assign meta_to_eng.ing_port    = in_tuser.ingress_port;
    assign meta_to_eng.egr_spec    = '0;
    assign meta_to_eng.prio        = '0;    // engine fills from table
    assign meta_to_eng.byte_length = in_tuser.byte_length;

    stream_sof u_sof (
        .clk    ( clk       ),
        .rst    ( rst       ),
        .tvalid ( in_tvalid ),
        .tready ( in_tready ),
        .tlast  ( in_tlast  ),
        .sof    ( sof       )
    );

    echo_engine #(
        .DATA_BYTES ( DATA_BYTES )
    ) u_engine (
        .clk           ( clk           ),
        .rst           ( rst           ),
        .s_tdata       ( in_tdata      ),
        .s_tkeep       ( in_tkeep      ),
        .s_tlast       ( in_tlast      ),
        .s_tvalid      ( in_tvalid     ),
        .s_tready      ( in_tready     ),
        .meta_in       ( meta_to_eng   ),
        .meta_in_valid ( sof           ),
        .m_tdata       ( out_tdata     ),
        .m_tkeep       ( out_tkeep     ),
        .m_tlast       ( out_tlast     ),
        .m_tvalid      ( out_tvalid    ),
        .m_tready      ( out_tready    ),
        .meta_out      ( meta_from_eng ),
        .ctrl_req      ( ctrl_req      ),
        .ctrl_rdata    ( ctrl_rdata    ),
        .meta_overflow ( meta_overflow )
    );

    ////////////////////////////////////////////////
    // egress side

    assign out_tuser.ingress_port = meta_from_eng.ing_port;
    assign out_tuser.egress_port  = egress_map(meta_from_eng.ing_port);
    assign out_tuser.prio         = meta_from_eng.prio;
    assign out_tuser.byte_length  = meta_from_eng.byte_length;

endmodule

/* logic/echo_engine.sv */
//////////////////////////////////////////////////
// echo match-action engine
// one-stage pass-through with priority lookup and frame count
//////////////////////////////////////////////////

`timescale 1ns/10ps

module echo_engine #(
    parameter int DATA_BYTES = router_pkg::DATA_BYTES
) (
    input  logic                            clk,
    input  logic                            rst,
    input  logic [DATA_BYTES*8-1:0]         s_tdata,
    input  logic [DATA_BYTES-1:0]           s_tkeep,
    input  logic                            s_tlast,
    input  logic                            s_tvalid,
    output logic                            s_tready,
    input  router_pkg::user_meta_t          meta_in,
    input  logic                            meta_in_valid,
    output logic [DATA_BYTES*8-1:0]         m_tdata,
    output logic [DATA_BYTES-1:0]           m_tkeep,
    output logic                            m_tlast,
    output logic                            m_tvalid,
    input  logic                            m_tready,
    output router_pkg::user_meta_t          meta_out,
    input  router_pkg::ctrl_req_t           ctrl_req,
    output logic [router_pkg::CTRL_DW-1:0]  ctrl_rdata,
    output logic                            meta_overflow
);

    import router_pkg::*;

    localparam int META_DEPTH = 4;              // two frames in flight at most

    typedef struct packed {
        logic [DATA_BYTES*8-1:0] data;
        logic [DATA_BYTES-1:0]   keep;
        logic                    last;
    } beat_t;

    beat_t             s_beat;
    beat_t             stage_q;                 // held output beat
    logic              stage_vld;
    logic              s_xfer;
    logic              m_xfer;
    logic              frame_end;
    user_meta_t        meta_push;
    logic              meta_empty;
    logic [PRIO_W-1:0] port_prio;

    ////////////////////////////////////////////////
    // data stage

    assign s_beat    = '{data: s_tdata, keep: s_tkeep, last: s_tlast};
    assign s_tready  = !stage_vld || m_tready;  // empty or draining
    assign s_xfer    = s_tvalid && s_tready;
    assign m_xfer    = stage_vld && m_tready;
    assign frame_end = m_xfer && stage_q.last;

    always_ff @(posedge clk) begin
        if (rst) begin
            stage_vld <= 1'b0;
        end else if (s_tready) begin
            stage_vld <= s_tvalid;
        end
    end

    always_ff @(posedge clk) begin
        if (s_xfer) begin
            stage_q <= s_beat;
        end
    end

    assign m_tdata  = stage_q.data;
    assign m_tkeep  = stage_q.keep;
    assign m_tlast  = stage_q.last;
    assign m_tvalid = stage_vld;

    ////////////////////////////////////////////////
    // metadata path

    always_comb begin
        meta_push      = meta_in;
        meta_push.prio = port_prio;             // table entry for the ingress port
    end

    meta_fifo #(
        .T     ( user_meta_t ),
        .DEPTH ( META_DEPTH  )
    ) u_meta_fifo (
        .clk       ( clk           ),
        .rst       ( rst           ),
        .push      ( meta_in_valid ),
        .push_data ( meta_push     ),
        .pop       ( frame_end     ),           // retire on last beat out
        .head      ( meta_out      ),
        .empty     ( meta_empty    ),
        .overflow  ( meta_overflow )
    );

    ctrl_regs u_ctrl_regs (
        .clk         ( clk              ),
        .rst         ( rst              ),
        .ctrl_req    ( ctrl_req         ),
        .frame_done  ( frame_end        ),
        .lookup_port ( meta_in.ing_port ),
        .lookup_prio ( port_prio        ),
        .rdata       ( ctrl_rdata       )
    );

    // every beat leaving has its frame's metadata at the head
    a_meta_present: assert property (@(posedge clk) disable iff (rst)
        m_tvalid |-> !meta_empty);

endmodule

/* logic/ctrl_regs.sv */
//////////////////////////////////////////////////
// control registers
// per-port priority table and forwarded-frame counter
//////////////////////////////////////////////////

`timescale 1ns/10ps

module ctrl_regs (
    input  logic                                clk,
    input  logic                                rst,
    input  router_pkg::ctrl_req_t               ctrl_req,
    input  logic                                frame_done,
    input  logic [router_pkg::PORT_W-1:0]       lookup_port,
    output logic [router_pkg::PRIO_W-1:0]       lookup_prio,
    output logic [router_pkg::CTRL_DW-1:0]      rdata
);

    import router_pkg::*;

    logic [PRIO_W-1:0]  prio_tab [NUM_PORTS];
    logic [CTRL_DW-1:0] frame_cnt;
    logic               tab_sel;                // address hits the table

    assign tab_sel     = (ctrl_req.addr < CTRL_AW'(NUM_PORTS));
    assign lookup_prio = prio_tab[lookup_port]; // same-cycle lookup for the engine

    ////////////////////////////////////////////////
    // writes and counting

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                prio_tab[i] <= '0;
            end
            frame_cnt <= '0;
        end else begin
            if (ctrl_req.wr && tab_sel) begin
                prio_tab[ctrl_req.addr[PORT_W-1:0]] <= ctrl_req.wdata[PRIO_W-1:0];
            end
            if (frame_done) begin
                frame_cnt <= frame_cnt + 1'b1;
            end
        end
    end

    ////////////////////////////////////////////////
    // combinational read-back from addr

    always_comb begin
        if (tab_sel) begin
            rdata = CTRL_DW'(prio_tab[ctrl_req.addr[PORT_W-1:0]]);
        end else if (ctrl_req.addr == CTRL_AW'(CNT_ADDR)) begin
            rdata = frame_cnt;
        end else begin
            rdata = '0;                         // unmapped
        end
    end

    // the bench only ever writes mapped addresses
    a_wr_addr: assert property (@(posedge clk) disable iff (rst)
        ctrl_req.wr |-> (ctrl_req.addr <= CTRL_AW'(CNT_ADDR)));

endmodule

/* logic/meta_fifo.sv */
//////////////////////////////////////////////////
// metadata FIFO
// holds per-frame metadata from frame start to frame end
//////////////////////////////////////////////////

`timescale 1ns/10ps

module meta_fifo #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 4
) (
    input  logic clk,
    input  logic rst,
    input  logic push,
    input  T     push_data,
    input  logic pop,
    output T     head,
    output logic empty,
    output logic overflow
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    T                 mem [DEPTH];              // payload storage
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             accept;                   // push that lands

    assign empty  = (count == '0);
    assign full   = (count == CNT_W'(DEPTH));
    assign accept = push && (!full || pop);     // a pop frees a slot this cycle
    assign head   = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (accept) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            overflow <= 1'b0;
        end else begin
            if (accept) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({accept, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;        // both or neither
            endcase
            if (push && !accept) begin
                overflow <= 1'b1;               // sticky until reset
            end
        end
    end

    a_no_underflow: assert property (@(posedge clk) disable iff (rst)
        pop |-> !empty);

endmodule

/* logic/stream_sof.sv */
//////////////////////////////////////////////////
// stream start-of-frame detect
// pulses on the first accepted beat of every frame
//////////////////////////////////////////////////

`timescale 1ns/10ps

module stream_sof (
    input  logic clk,
    input  logic rst,
    input  logic tvalid,
    input  logic tready,
    input  logic tlast,
    output logic sof
);

    logic xfer;
    logic in_frame;                             // set between first and last beat

    assign xfer = tvalid && tready;
    assign sof  = xfer && !in_frame;            // first beat of the frame

    always_ff @(posedge clk) begin
        if (rst) begin
            in_frame <= 1'b0;
        end else if (xfer) begin
            in_frame <= !tlast;                 // single-beat frame stays out
        end
    end

    // source keeps valid and last steady until the handshake
    a_src_hold: assert property (@(posedge clk) disable iff (rst)
        (tvalid && !tready) |=> (tvalid && $stable(tlast)));

endmodule

/* logic/router_pkg.sv */
//////////////////////////////////////////////////
// router package
// port and field widths, metadata and control request structs
//////////////////////////////////////////////////

package router_pkg;

    ////////////////////////////////////////////////
    // widths

    localparam int PORT_W     = 4;              // 16 ports
    localparam int NUM_PORTS  = 1 << PORT_W;
    localparam int PRIO_W     = 3;
    localparam int LEN_W      = 16;             // frame length in bytes
    localparam int DATA_BYTES = 8;              // default stream width
    localparam int CTRL_AW    = 5;
    localparam int CTRL_DW    = 32;
    localparam int CNT_ADDR   = NUM_PORTS;      // frame count sits just past the table

    ////////////////////////////////////////////////
    // metadata

    // sampled from in_tuser on the first beat
    typedef struct packed {
        logic [PORT_W-1:0] ingress_port;
        logic [LEN_W-1:0]  byte_length;
    } ing_meta_t;

    // match-action engine's own view
    typedef struct packed {
        logic [PORT_W-1:0] ing_port;
        logic [PORT_W-1:0] egr_spec;
        logic [PRIO_W-1:0] prio;
        logic [LEN_W-1:0]  byte_length;
    } user_meta_t;

    // driven on out_tuser for every beat of a frame
    typedef struct packed {
        logic [PORT_W-1:0] ingress_port;
        logic [PORT_W-1:0] egress_port;
        logic [PRIO_W-1:0] prio;
        logic [LEN_W-1:0]  byte_length;
    } egr_meta_t;

    typedef struct packed {
        logic               wr;                 // one-cycle write strobe
        logic [CTRL_AW-1:0] addr;
        logic [CTRL_DW-1:0] wdata;
    } ctrl_req_t;

endpackage
